//--- verilog/noc_macros.svh
// Width and depth constants for the router node.
// Included by the package and by the input FIFO.

`ifndef NOC_MACROS_SVH
`define NOC_MACROS_SVH

// One tail bit on top of a ten bit payload
`define NOC_FLIT_W 11

// Entries in each input FIFO
// The FIFO full flag relies on this being a power of two
`define NOC_FIFO_DEPTH 8

`endif

//--- verilog/noc_pkg.sv
// Types shared by the router node RTL and its testbench.
// Import it inside a module body; use scoped names in port lists.

`include "noc_macros.svh"

package noc_pkg;

	// Signed hop count carried in the payload of a header flit
	typedef logic [`NOC_FLIT_W-2:0] hop_t;

	// One flit on a link
	// The payload is a hop_t in a header and plain data in a body flit
	typedef struct packed {
		logic                    tail;
		logic [`NOC_FLIT_W-2:0] payload;
	} flit_t;

	// Input controller FSM states
	typedef enum logic [1:0] {
		ic_idle,
		ic_parse,
		ic_send_0,
		ic_send_1
	} ic_state_t;

endpackage

//--- verilog/flit_fifo.sv
// Input buffer for one router port.
// Circular buffer with a combinational head; push is ignored while full
// and read is ignored while empty.

`timescale 1ns/1ps
`include "noc_macros.svh"

module flit_fifo (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           push,
	input  noc_pkg::flit_t push_flit,
	input  logic           read,
	output noc_pkg::flit_t pop_flit,
	output logic           empty,
	output logic           full
);
	import noc_pkg::*;

	localparam int ptr_w = $clog2(`NOC_FIFO_DEPTH);

	flit_t            mem [`NOC_FIFO_DEPTH];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [ptr_w:0]   count;
	logic             do_push;
	logic             do_pop;

	// Qualified strobes, a write needs room and a read needs data
	assign do_push = push && !full;
	assign do_pop  = read && !empty;

	assign empty = (count == '0);
	// With a power of two depth the count only reaches its top bit when full
	assign full  = count[ptr_w];

	// Head of the queue is shown straight from the storage
	assign pop_flit = mem[rd_ptr];

	// Storage array
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_flit;
		end
	end

	// Pointers wrap on their own since the depth is a power of two
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// Occupancy only moves when exactly one side is active
			case ({do_push, do_pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/input_controller.sv
// Input controller for one router port.
// Reads a header from its FIFO, picks an output from the signed hop field,
// rewrites the header and streams the packet to that output's allocator.

`timescale 1ns/1ps

module input_controller (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           empty,
	input  noc_pkg::flit_t in_flit,
	input  logic           ready_0,
	input  logic           ready_1,
	output logic           read,
	output logic           req_0,
	output logic           req_1,
	output noc_pkg::flit_t out_flit
);
	import noc_pkg::*;

	ic_state_t state;
	ic_state_t next_state;
	hop_t      hop;
	hop_t      new_hop;
	logic      to_out_1;
	flit_t     hdr_flit;
	logic      hdr_pending;
	logic      have_flit;
	logic      move;

	// Hop field of the flit at the FIFO head, only meaningful in parse
	assign hop = in_flit.payload;

	// Strictly positive means sign bit clear and some bit set
	assign to_out_1 = !hop[$bits(hop_t)-1] && (|hop);

	// Positive hops count down on the way to output 1
	// Zero or negative hops are negated on the way to output 0
	assign new_hop = to_out_1 ? (hop - hop_t'(1)) : -hop;

	// The rewritten header is offered first, then body flits straight
	// from the FIFO head
	assign out_flit = hdr_pending ? hdr_flit : in_flit;

	// There is something to offer if the header is still held or a body
	// flit has arrived in the FIFO
	assign have_flit = hdr_pending || !empty;

	assign req_0 = (state == ic_send_0) && have_flit;
	assign req_1 = (state == ic_send_1) && have_flit;

	// A flit leaves on any cycle where the chosen allocator takes it
	assign move = (req_0 && ready_0) || (req_1 && ready_1);

	// The header is popped during parse, body flits as they are accepted
	assign read = ((state == ic_parse) && !empty) || (move && !hdr_pending);

	// Next state logic
	always_comb begin
		next_state = state;
		case (state)
			ic_idle: begin
				if (!empty) begin
					next_state = ic_parse;
				end
			end
			ic_parse: begin
				// After a body tail the FIFO can turn out empty here,
				// so fall back to idle without forming a header
				if (empty) begin
					next_state = ic_idle;
				end else if (to_out_1) begin
					next_state = ic_send_1;
				end else begin
					next_state = ic_send_0;
				end
			end
			ic_send_0, ic_send_1: begin
				if (move && out_flit.tail) begin
					next_state = empty ? ic_idle : ic_parse;
				end
			end
			default: next_state = ic_idle;
		endcase
	end

	// State and header bookkeeping
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= ic_idle;
			hdr_pending <= 1'b0;
		end else begin
			state <= next_state;
			if ((state == ic_parse) && !empty) begin
				hdr_pending <= 1'b1;
			end else if (move) begin
				hdr_pending <= 1'b0;
			end
		end
	end

	// Rewritten header register, tail bit passes through untouched
	always_ff @(posedge clk) begin
		if ((state == ic_parse) && !empty) begin
			hdr_flit.tail    <= in_flit.tail;
			hdr_flit.payload <= new_hop;
		end
	end

endmodule

//--- verilog/output_allocator.sv
// Output allocator for one router output.
// Grants the port to one of two input controllers for a whole packet,
// rotating priority after each tail, and registers the outgoing flit.

`timescale 1ns/1ps

module output_allocator (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           req_a,
	input  logic           req_b,
	input  noc_pkg::flit_t flit_a,
	input  noc_pkg::flit_t flit_b,
	input  logic           out_ready,
	output logic           ready_a,
	output logic           ready_b,
	output logic           out_valid,
	output noc_pkg::flit_t out_flit
);
	import noc_pkg::*;

	logic  locked;
	logic  owner_b;
	logic  prio_b;
	logic  sel_a;
	logic  sel_b;
	logic  move_a;
	logic  move_b;
	logic  move;
	flit_t mux_flit;

	// While a packet is in flight the grant stays with its owner
	// Otherwise a new requester is picked at once so a header can pass
	// in the same cycle its request rises
	always_comb begin
		if (locked) begin
			sel_a = !owner_b;
			sel_b = owner_b;
		end else begin
			sel_a = req_a && (!prio_b || !req_b);
			sel_b = req_b && (prio_b || !req_a);
		end
	end

	// Ready only goes out to the selected side and only while the
	// downstream side can take a flit
	assign ready_a = out_ready && sel_a;
	assign ready_b = out_ready && sel_b;

	assign move_a = req_a && ready_a;
	assign move_b = req_b && ready_b;
	assign move   = move_a || move_b;

	assign mux_flit = move_b ? flit_b : flit_a;

	// Grant and round-robin pointer
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			locked  <= 1'b0;
			owner_b <= 1'b0;
			prio_b  <= 1'b0;
		end else if (move) begin
			if (mux_flit.tail) begin
				// Release and hand priority to the side not just served
				locked <= 1'b0;
				prio_b <= move_a;
			end else begin
				locked  <= 1'b1;
				owner_b <= move_b;
			end
		end
	end

	// Valid strobe only updates while downstream is ready, so a presented
	// flit holds during back-pressure
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
		end else if (out_ready) begin
			out_valid <= move;
		end
	end

	// Output data register
	always_ff @(posedge clk) begin
		if (move) begin
			out_flit <= mux_flit;
		end
	end

endmodule

//--- verilog/router_node.sv
// One node of a 1-D wormhole router with two inputs and two outputs.
// Each input runs FIFO then controller; each output has its own allocator
// fed by both controllers.

`timescale 1ns/1ps

module router_node (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           in_push_0,
	input  logic           in_push_1,
	input  noc_pkg::flit_t in_flit_0,
	input  noc_pkg::flit_t in_flit_1,
	input  logic           out_ready_0,
	input  logic           out_ready_1,
	output logic           in_full_0,
	output logic           in_full_1,
	output logic           out_valid_0,
	output logic           out_valid_1,
	output noc_pkg::flit_t out_flit_0,
	output noc_pkg::flit_t out_flit_1
);
	import noc_pkg::*;

	// FIFO to controller, per input
	flit_t head_0;
	flit_t head_1;
	logic  empty_0;
	logic  empty_1;
	logic  read_0;
	logic  read_1;

	// Controller to allocator, named ic<input>_<output>
	flit_t ic0_flit;
	flit_t ic1_flit;
	logic  ic0_req_0;
	logic  ic0_req_1;
	logic  ic1_req_0;
	logic  ic1_req_1;
	logic  ic0_ready_0;
	logic  ic0_ready_1;
	logic  ic1_ready_0;
	logic  ic1_ready_1;

	// Input side, port 0
	flit_fifo fifo_0 (
		.clk(clk), .rst_n(rst_n), .push(in_push_0), .push_flit(in_flit_0),
		.read(read_0), .pop_flit(head_0), .empty(empty_0), .full(in_full_0)
	);
	input_controller ic_0 (
		.clk(clk), .rst_n(rst_n), .empty(empty_0), .in_flit(head_0),
		.ready_0(ic0_ready_0), .ready_1(ic0_ready_1), .read(read_0),
		.req_0(ic0_req_0), .req_1(ic0_req_1), .out_flit(ic0_flit)
	);

	// Input side, port 1
	flit_fifo fifo_1 (
		.clk(clk), .rst_n(rst_n), .push(in_push_1), .push_flit(in_flit_1),
		.read(read_1), .pop_flit(head_1), .empty(empty_1), .full(in_full_1)
	);
	input_controller ic_1 (
		.clk(clk), .rst_n(rst_n), .empty(empty_1), .in_flit(head_1),
		.ready_0(ic1_ready_0), .ready_1(ic1_ready_1), .read(read_1),
		.req_0(ic1_req_0), .req_1(ic1_req_1), .out_flit(ic1_flit)
	);

	// Output 0 collects every req_0, input 0 on side a
	output_allocator alloc_0 (
		.clk(clk), .rst_n(rst_n), .req_a(ic0_req_0), .req_b(ic1_req_0),
		.flit_a(ic0_flit), .flit_b(ic1_flit), .out_ready(out_ready_0),
		.ready_a(ic0_ready_0), .ready_b(ic1_ready_0),
		.out_valid(out_valid_0), .out_flit(out_flit_0)
	);

	// Output 1 collects every req_1
	output_allocator alloc_1 (
		.clk(clk), .rst_n(rst_n), .req_a(ic0_req_1), .req_b(ic1_req_1),
		.flit_a(ic0_flit), .flit_b(ic1_flit), .out_ready(out_ready_1),
		.ready_a(ic0_ready_1), .ready_b(ic1_ready_1),
		.out_valid(out_valid_1), .out_flit(out_flit_1)
	);

endmodule

//--- testbench/router_checker.sv
// Scoreboard for the router node testbench.
// The testbench registers each packet with add_packet, then this module
// matches every flit leaving either output against the expected packet
// and checks that neither input FIFO reports full too early.

`timescale 1ns/1ps
`include "noc_macros.svh"

module router_checker (
	input logic           clk,
	input logic           rst_n,
	input logic           in_push_0,
	input logic           in_push_1,
	input logic           in_full_0,
	input logic           in_full_1,
	input logic           out_valid_0,
	input logic           out_valid_1,
	input logic           out_ready_0,
	input logic           out_ready_1,
	input noc_pkg::flit_t out_flit_0,
	input noc_pkg::flit_t out_flit_1
);
	import noc_pkg::*;

	int errors = 0;
	int received = 0;

	// Expected packets, indexed by the id carried in the body words
	bit    known [32];
	bit    started [32];
	bit    done [32];
	string name [32];
	int    grp [32];
	int    mode [32];
	int    in_port [32];
	int    exp_port [32];
	int    nbody [32];
	flit_t exp_hdr [32];
	flit_t body [32][4];

	// Per output tracking of the packet currently passing
	bit    busy [2];
	int    cur [2];
	int    idx [2];
	flit_t hold_hdr [2];
	bit    last_valid [2];
	int    last_in [2];

	// Per input flit accounting for the full flag
	int    pushed [2];
	int    delivered [2];
	string in_test [2] = '{"idle", "idle"};

	task automatic add_packet(input int id, input string nm, input int g, input int md,
			input int ip, input int ep, input flit_t hdr, input int nb,
			input flit_t b0, input flit_t b1, input flit_t b2, input flit_t b3);
		known[id]    = 1'b1;
		started[id]  = 1'b0;
		done[id]     = 1'b0;
		name[id]     = nm;
		grp[id]      = g;
		mode[id]     = md;
		in_port[id]  = ip;
		exp_port[id] = ep;
		exp_hdr[id]  = hdr;
		nbody[id]    = nb;
		body[id][0]  = b0;
		body[id][1]  = b1;
		body[id][2]  = b2;
		body[id][3]  = b3;
		in_test[ip]  = nm;
	endtask

	function automatic int pending_count();
		int n;
		n = 0;
		for (int k = 0; k < 32; k++) begin
			if (known[k] && !done[k]) begin
				n++;
			end
		end
		return n;
	endfunction

	task automatic report_missing();
		for (int k = 0; k < 32; k++) begin
			if (known[k] && !done[k]) begin
				$display("packet %0d of test %s never arrived complete on output %0d",
					k, name[k], exp_port[k]);
			end
		end
	endtask

	// A flit that opened a packet after the last tail was never asked for
	task automatic check_outputs_idle();
		for (int o = 0; o < 2; o++) begin
			if (busy[o]) begin
				$display("stray flit %h left on output %0d after the last packet",
					hold_hdr[o], o);
				errors++;
			end
		end
	endtask

	// A FIFO can only be full once a whole depth of pushed flits
	// has not yet come out of an output
	task automatic check_full_flag(input int p, input logic full);
		int held;
		held = pushed[p] - delivered[p];
		if (held < `NOC_FIFO_DEPTH && full !== 1'b0) begin
			$display("mismatch test=%s in_full_%0d expected=0 actual=%b",
				in_test[p], p, full);
			errors++;
		end
	endtask

	// On a contended output an input may not be served twice in a row
	// while the other input still waits with a packet for that output
	// The previous packet may belong to an earlier group, so the first
	// packet of a group must come from the input that was not served last
	task automatic check_round_robin(input int o, input int id);
		if (mode[id] == 1 && last_valid[o] && last_in[o] == in_port[id]) begin
			for (int q = 0; q < 32; q++) begin
				if (known[q] && !started[q] && grp[q] == grp[id] &&
						in_port[q] != in_port[id] && exp_port[q] == o) begin
					$display("round-robin order broken in test %s: input %0d twice on output %0d",
						name[id], in_port[id], o);
					errors++;
					break;
				end
			end
		end
		last_valid[o] = 1'b1;
		last_in[o]    = in_port[id];
	endtask

	task automatic handle_flit(input int o, input flit_t f);
		int id;
		flit_t exp;
		if (!busy[o]) begin
			// First flit of a packet whose id only shows in the next flit
			hold_hdr[o] = f;
			busy[o]     = 1'b1;
			idx[o]      = 0;
			return;
		end
		if (idx[o] == 0) begin
			id = int'(f.payload[9:5]);
			if (!known[id] || started[id] || exp_port[id] != o) begin
				$display("unexpected flit %h on output %0d, no open packet with id %0d",
					f, o, id);
				errors++;
				busy[o] = 1'b0;
				return;
			end
			started[id] = 1'b1;
			cur[o] = id;
			delivered[in_port[id]]++;
			check_round_robin(o, id);
			if (hold_hdr[o] !== exp_hdr[id]) begin
				$display("mismatch test=%s packet=%0d header expected=%h actual=%h",
					name[id], id, exp_hdr[id], hold_hdr[o]);
				errors++;
			end
		end
		id = cur[o];
		exp = body[id][idx[o]];
		delivered[in_port[id]]++;
		if (f !== exp) begin
			$display("mismatch test=%s packet=%0d flit=%0d expected=%h actual=%h",
				name[id], id, idx[o] + 1, exp, f);
			errors++;
		end
		idx[o]++;
		// Packet closes on the arriving tail or on the expected length
		if (f.tail || idx[o] == nbody[id]) begin
			done[id] = 1'b1;
			busy[o]  = 1'b0;
			received++;
		end
	endtask

	// A flit is taken downstream on an edge with valid and ready both high
	always @(posedge clk) begin
		if (rst_n) begin
			check_full_flag(0, in_full_0);
			check_full_flag(1, in_full_1);
		end
		// Pushes are only driven while the FIFO has room
		if (in_push_0 === 1'b1) begin
			pushed[0]++;
		end
		if (in_push_1 === 1'b1) begin
			pushed[1]++;
		end
		if (out_valid_0 && out_ready_0) begin
			handle_flit(0, out_flit_0);
		end
		if (out_valid_1 && out_ready_1) begin
			handle_flit(1, out_flit_1);
		end
	end

endmodule

//--- testbench/router_node_tb.sv
// Testbench for the router node.
// Reads packets from the input file, drives both inputs group by group
// and applies random back-pressure where the file asks for it.

`timescale 1ns/1ps

module router_node_tb;
	import noc_pkg::*;

	logic  clk;
	logic  rst_n;
	logic  in_push_0;
	logic  in_push_1;
	flit_t in_flit_0;
	flit_t in_flit_1;
	logic  out_ready_0;
	logic  out_ready_1;
	logic  in_full_0;
	logic  in_full_1;
	logic  out_valid_0;
	logic  out_valid_1;
	flit_t out_flit_0;
	flit_t out_flit_1;

	// Packets as read from the file
	string pk_name [32];
	int    pk_grp [32];
	int    pk_mode [32];
	int    pk_port [32];
	int    pk_nb [32];
	int    pk_exp_port [32];
	hop_t  pk_hop [32];
	hop_t  pk_exp_hdr [32];
	hop_t  pk_body [32][4];
	int    npk = 0;
	int    total_flits = 0;
	int    limit = 0;
	bit    limit_set = 1'b0;
	int    cycles = 0;
	int    tb_errors = 0;
	logic [31:0] rnd = 32'd18483;

	router_node router_node_i (
		.clk(clk), .rst_n(rst_n), .in_push_0(in_push_0), .in_push_1(in_push_1),
		.in_flit_0(in_flit_0), .in_flit_1(in_flit_1),
		.out_ready_0(out_ready_0), .out_ready_1(out_ready_1),
		.in_full_0(in_full_0), .in_full_1(in_full_1),
		.out_valid_0(out_valid_0), .out_valid_1(out_valid_1),
		.out_flit_0(out_flit_0), .out_flit_1(out_flit_1)
	);

	router_checker check (
		.clk(clk), .rst_n(rst_n), .in_push_0(in_push_0), .in_push_1(in_push_1),
		.in_full_0(in_full_0), .in_full_1(in_full_1),
		.out_valid_0(out_valid_0), .out_valid_1(out_valid_1),
		.out_ready_0(out_ready_0), .out_ready_1(out_ready_1),
		.out_flit_0(out_flit_0), .out_flit_1(out_flit_1)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic read_packets();
		int fd;
		int n;
		string line;
		fd = $fopen("testbench/router_input.txt", "r");
		if (fd == 0) begin
			$display("cannot open testbench/router_input.txt");
			tb_errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			if (line.len() == 0 || line[0] == "#") begin
				continue;
			end
			n = $sscanf(line, "%s %d %d %d %h %d %h %h %h %h %d %h",
				pk_name[npk], pk_grp[npk], pk_mode[npk], pk_port[npk], pk_hop[npk],
				pk_nb[npk], pk_body[npk][0], pk_body[npk][1], pk_body[npk][2],
				pk_body[npk][3], pk_exp_port[npk], pk_exp_hdr[npk]);
			if (n == 12) begin
				total_flits += pk_nb[npk] + 1;
				npk++;
			end
		end
		$fclose(fd);
	endtask

	// Random ready levels only in back-pressure groups
	task automatic set_ready(input int md);
		if (md == 2) begin
			rnd = xorshift32(rnd);
			out_ready_0 <= rnd[0];
			out_ready_1 <= rnd[9];
		end else begin
			out_ready_0 <= 1'b1;
			out_ready_1 <= 1'b1;
		end
	endtask

	task automatic run_group(input int first, input int last);
		flit_t q0 [$];
		flit_t q1 [$];
		flit_t f;
		flit_t b [4];
		int md;
		int id;
		md = pk_mode[first];
		for (int k = first; k < last; k++) begin
			id = int'(pk_body[k][0][9:5]);
			for (int j = 0; j < 4; j++) begin
				b[j].tail    = (j == pk_nb[k] - 1);
				b[j].payload = pk_body[k][j];
			end
			f.tail    = 1'b0;
			f.payload = pk_exp_hdr[k];
			check.add_packet(id, pk_name[k], pk_grp[k], md, pk_port[k], pk_exp_port[k],
				f, pk_nb[k], b[0], b[1], b[2], b[3]);
			f.payload = pk_hop[k];
			if (pk_port[k] == 0) begin
				q0.push_back(f);
			end else begin
				q1.push_back(f);
			end
			for (int j = 0; j < pk_nb[k]; j++) begin
				if (pk_port[k] == 0) begin
					q0.push_back(b[j]);
				end else begin
					q1.push_back(b[j]);
				end
			end
		end
		// Both inputs are fed at once so packets can meet at an output
		while (q0.size() != 0 || q1.size() != 0) begin
			@(posedge clk);
			set_ready(md);
			if (q0.size() != 0 && !in_full_0) begin
				in_push_0 <= 1'b1;
				in_flit_0 <= q0.pop_front();
			end else begin
				in_push_0 <= 1'b0;
			end
			if (q1.size() != 0 && !in_full_1) begin
				in_push_1 <= 1'b1;
				in_flit_1 <= q1.pop_front();
			end else begin
				in_push_1 <= 1'b0;
			end
		end
		while (check.pending_count() != 0) begin
			@(posedge clk);
			in_push_0 <= 1'b0;
			in_push_1 <= 1'b0;
			set_ready(md);
		end
		@(posedge clk);
		out_ready_0 <= 1'b1;
		out_ready_1 <= 1'b1;
	endtask

	initial begin
		int i;
		int j;
		int total;
		rst_n       = 1'b0;
		in_push_0   = 1'b0;
		in_push_1   = 1'b0;
		in_flit_0   = '0;
		in_flit_1   = '0;
		out_ready_0 = 1'b1;
		out_ready_1 = 1'b1;
		read_packets();
		limit = 40 * total_flits;
		limit_set = 1'b1;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		i = 0;
		while (i < npk) begin
			j = i;
			while (j < npk && pk_grp[j] == pk_grp[i]) begin
				j++;
			end
			run_group(i, j);
			i = j;
		end
		check.check_outputs_idle();
		if (npk == 0) begin
			$display("no packets were read from the input file");
			tb_errors++;
		end
		total = check.errors + tb_errors;
		$display("errors: checker %0d, testbench %0d, packets received %0d of %0d",
			check.errors, tb_errors, check.received, npk);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

	// Watchdog whose limit comes from the number of flits in the file
	always @(posedge clk) begin
		if (limit_set) begin
			cycles++;
			if (cycles > limit) begin
				$display("timeout after %0d cycles with packets still missing", cycles);
				check.report_missing();
				$display("errors: checker %0d, testbench %0d, packets received %0d of %0d",
					check.errors, tb_errors + 1, check.received, npk);
				$display("** FAIL **");
				$finish;
			end
		end
	end

endmodule

//--- testbench/router_input.txt
# name group mode(0 plain,1 contention,2 back-pressure) in_port hop nbody
# body0..body3 (hex, body word = id<<5 | seq) exp_port exp_header(hex)
# Routing, positive hops to output 1, zero or negative to output 0
pos_hop      1 0 0 003 3 020 021 022 000 1 002
zero_hop     1 0 1 000 2 040 041 000 000 0 000
neg_hop      2 0 0 3fe 2 060 061 000 000 0 002
one_hop      2 0 1 001 3 080 081 082 000 1 000
max_hop      3 0 0 1ff 1 0a0 000 000 000 1 1fe
min_hop      3 0 1 200 2 0c0 0c1 000 000 0 200
# Back-to-back packets in one FIFO, each routed by its own header
b2b_first    4 0 0 005 2 0e0 0e1 000 000 1 004
b2b_second   4 0 0 3ff 3 100 101 102 000 0 001
b2b_other    4 0 1 3fb 1 120 000 000 000 0 005
# Both inputs compete for output 1
cont1_a0     5 1 0 002 2 140 141 000 000 1 001
cont1_a1     5 1 0 004 2 160 161 000 000 1 003
cont1_b0     5 1 1 007 2 180 181 000 000 1 006
cont1_b1     5 1 1 001 2 1a0 1a1 000 000 1 000
# Both inputs compete for output 0
cont0_a0     6 1 0 3f0 2 1c0 1c1 000 000 0 010
cont0_a1     6 1 0 000 2 1e0 1e1 000 000 0 000
cont0_b0     6 1 1 3fc 2 200 201 000 000 0 004
cont0_b1     6 1 1 3fd 2 220 221 000 000 0 003
# Random back-pressure on both outputs
bp_a0        7 2 0 010 3 240 241 242 000 1 00f
bp_a1        7 2 0 3e0 2 260 261 000 000 0 020
bp_b0        7 2 1 3f8 3 280 281 282 000 0 008
bp_b1        7 2 1 006 2 2a0 2a1 000 000 1 005
bp_same_a    8 2 0 001 3 2c0 2c1 2c2 000 1 000
bp_same_b    8 2 1 3ff 3 2e0 2e1 2e2 000 0 001
bp_share_a   9 2 0 00a 2 300 301 000 000 1 009
bp_share_b   9 2 1 00b 2 320 321 000 000 1 00a

//--- sources.f
+incdir+verilog
verilog/noc_pkg.sv
verilog/flit_fifo.sv
verilog/input_controller.sv
verilog/output_allocator.sv
verilog/router_node.sv
testbench/router_checker.sv
testbench/router_node_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the router node testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sources.f --top-module router_node_tb \
	--Mdir obj_dir -o router_node_tb_sim > build.log 2>&1 \
	|| { echo "build failed, see build.log"; exit 1; }

./obj_dir/router_node_tb_sim > sim.log 2>&1
grep -q "\*\* FAIL \*\*" sim.log && { echo "simulation failed, see sim.log"; exit 1; } \
	|| grep -q "\*\* PASS \*\*" sim.log && { echo "simulation passed"; exit 0; } \
	|| { echo "simulation ended without a result, see sim.log"; exit 1; }
